//--- Bender.yml
package:
  name: cpu

sources:
  - verilog/cpu_pkg.sv
  - verilog/register_file.sv
  - verilog/alu.sv
  - verilog/datapath.sv
  - verilog/control_unit.sv
  - verilog/cpu_top.sv
  - target: test
    files:
      - test/cpu_tb.sv

//--- all.f
verilog/cpu_pkg.sv
verilog/register_file.sv
verilog/alu.sv
verilog/datapath.sv
verilog/control_unit.sv
verilog/cpu_top.sv
test/cpu_tb.sv

//--- test/cpu_tb.sv
`timescale 1ns/1ns
`default_nettype none

module cpu_tb;

	localparam int word_width = cpu_pkg::word_width;
	localparam logic [word_width-1:0] reset_pc = 32'h10;
	localparam int mem_depth = 256;
	localparam int run_limit = 400;

	typedef struct packed {
		cpu_pkg::opcode_e op;
		logic [word_width-1:0] a;
		logic [word_width-1:0] b;
		logic rand_a;
		logic rand_b;
		logic [18:0] imm;
		logic [word_width-1:0] addr;
	} row_t;

	logic clk;
	logic reset;
	logic pready;
	logic [word_width-1:0] prdata;
	logic psel;
	logic penable;
	logic pwrite;
	logic [word_width-1:0] paddr;
	logic [word_width-1:0] pwdata;
	logic halted;

	logic [word_width-1:0] mem [mem_depth];
	row_t table_rows [$];

	// Expected APB transfers, in bus order
	logic [word_width-1:0] expect_addr [$];
	logic expect_write [$];
	logic [word_width-1:0] expect_data [$];

	cpu_top #(
		.reset_pc(reset_pc)
	) uut (
		.clk(clk),
		.reset(reset),
		.pready(pready),
		.prdata(prdata),
		.psel(psel),
		.penable(penable),
		.pwrite(pwrite),
		.paddr(paddr),
		.pwdata(pwdata),
		.halted(halted)
	);

	always #2 clk = ~clk;

	task automatic report_failure(input string what);
		$display("%s", what);
		$display("Verification failed");
		$fatal(1);
	endtask

	task automatic check_word(input string name, input logic [word_width-1:0] actual,
			input logic [word_width-1:0] expected);
		if (actual !== expected)
			report_failure($sformatf("Error: %s is 0x%h, expected 0x%h", name, actual, expected));
	endtask

	task automatic check_flag(input string name, input logic actual, input logic expected);
		if (actual !== expected)
			report_failure($sformatf("Error: %s is 0x%h, expected 0x%h", name, actual, expected));
	endtask

	// Background contents, different for every address
	function automatic logic [word_width-1:0] fill_word(input logic [word_width-1:0] addr);
		return (addr * 32'h9e37_79b9) ^ 32'hc3a5_0f1e;
	endfunction

	function automatic logic [word_width-1:0] sign_extend(input logic [18:0] c);
		return {{(word_width - 19){c[18]}}, c};
	endfunction

	function automatic logic [word_width-1:0] encode(input cpu_pkg::opcode_e op,
			input logic [3:0] ra, input logic [3:0] rb, input logic [18:0] field);
		return {op, ra, rb, field};
	endfunction

	// Result of an ALU instruction with Y = a and bus = b
	function automatic logic [word_width-1:0] alu_rule(input cpu_pkg::opcode_e op,
			input logic [word_width-1:0] a, input logic [word_width-1:0] b);
		logic [2*word_width-1:0] doubled;
		logic [4:0] n;
		logic [word_width-1:0] result;
		n = b[4:0];
		doubled = {a, a};
		case (op)
			cpu_pkg::op_add, cpu_pkg::op_addi, cpu_pkg::op_ldi: result = a + b;
			cpu_pkg::op_sub: result = a - b;
			cpu_pkg::op_shr: result = a >> n;
			cpu_pkg::op_shra: result = $signed(a) >>> n;
			cpu_pkg::op_shl: result = a << n;
			cpu_pkg::op_ror: result = doubled >> n;
			cpu_pkg::op_rol: result = doubled[2*word_width-1-n -: word_width];
			cpu_pkg::op_and, cpu_pkg::op_andi: result = a & b;
			cpu_pkg::op_or, cpu_pkg::op_ori: result = a | b;
			cpu_pkg::op_neg: result = 0 - b;
			cpu_pkg::op_not: result = ~b;
			default: result = '0;
		endcase
		return result;
	endfunction

	task automatic add_row(input cpu_pkg::opcode_e op, input logic [word_width-1:0] a,
			input logic [word_width-1:0] b, input logic rand_a, input logic rand_b,
			input logic [18:0] imm, input logic [word_width-1:0] addr);
		row_t row;
		row.op = op;
		row.a = a;
		row.b = b;
		row.rand_a = rand_a;
		row.rand_b = rand_b;
		row.imm = imm;
		row.addr = addr;
		table_rows.push_back(row);
	endtask

	// Register rows carry rc = 3 in the constant field
	task automatic build_table;
		add_row(cpu_pkg::op_add, 0, 0, 1, 1, 19'h18000, 32'h80);
		add_row(cpu_pkg::op_sub, 0, 0, 1, 1, 19'h18000, 32'h81);
		add_row(cpu_pkg::op_shr, 0, 0, 1, 1, 19'h18000, 32'h82);
		add_row(cpu_pkg::op_shra, 32'h8000_f00f, 32'h7, 0, 0, 19'h18000, 32'h83);
		add_row(cpu_pkg::op_shl, 0, 0, 1, 1, 19'h18000, 32'h84);
		add_row(cpu_pkg::op_ror, 0, 32'h20, 1, 0, 19'h18000, 32'h85);
		add_row(cpu_pkg::op_rol, 0, 0, 1, 1, 19'h18000, 32'h86);
		add_row(cpu_pkg::op_and, 0, 0, 1, 1, 19'h18000, 32'h87);
		add_row(cpu_pkg::op_or, 0, 0, 1, 1, 19'h18000, 32'h88);
		add_row(cpu_pkg::op_addi, 0, 0, 1, 1, 19'h7fff0, 32'h89);
		add_row(cpu_pkg::op_andi, 0, 0, 1, 1, 19'h3ff0f, 32'h8a);
		add_row(cpu_pkg::op_ori, 0, 0, 1, 1, 19'h40001, 32'h8b);
		add_row(cpu_pkg::op_ldi, 32'h1000, 0, 0, 1, 19'h00123, 32'h8c);
		add_row(cpu_pkg::op_neg, 0, 0, 1, 1, 19'h0, 32'h8d);
		add_row(cpu_pkg::op_not, 0, 0, 1, 1, 19'h0, 32'h8e);
		// Base plus negative constant
		add_row(cpu_pkg::op_ld, 32'h50, 0, 0, 1, 19'h7fffd, 32'h8f);
		add_row(cpu_pkg::op_st, 32'h60, 0, 0, 1, 19'h00005, 32'h90);
	endtask

	task automatic expect_transfer(input logic [word_width-1:0] addr, input logic write,
			input logic [word_width-1:0] data);
		expect_addr.push_back(addr);
		expect_write.push_back(write);
		expect_data.push_back(data);
	endtask

	// R2 and R3 from memory, the row's op into R1, store R1, halt
	task automatic load_program(input row_t row);
		logic [word_width-1:0] r1;
		logic [word_width-1:0] target;
		expect_addr.delete();
		expect_write.delete();
		expect_data.delete();
		for (int i = 0; i < mem_depth; i++)
			mem[i] = fill_word(i);
		mem[32'h40] = row.a;
		mem[32'h41] = row.b;
		mem[reset_pc] = encode(cpu_pkg::op_ld, 4'd2, 4'd0, 19'h40);
		mem[reset_pc + 1] = encode(cpu_pkg::op_ld, 4'd3, 4'd0, 19'h41);
		if (row.op == cpu_pkg::op_st)
			mem[reset_pc + 2] = encode(row.op, 4'd3, 4'd2, row.imm);
		else
			mem[reset_pc + 2] = encode(row.op, 4'd1, 4'd2, row.imm);
		mem[reset_pc + 3] = encode(cpu_pkg::op_st, 4'd1, 4'd0, row.addr[18:0]);
		mem[reset_pc + 4] = encode(cpu_pkg::op_halt, 4'd0, 4'd0, 19'h0);

		r1 = '0;
		target = row.a + sign_extend(row.imm);
		expect_transfer(reset_pc, 1'b0, 0);
		expect_transfer(32'h40, 1'b0, 0);
		expect_transfer(reset_pc + 1, 1'b0, 0);
		expect_transfer(32'h41, 1'b0, 0);
		expect_transfer(reset_pc + 2, 1'b0, 0);
		case (row.op)
			cpu_pkg::op_ld: begin
				expect_transfer(target, 1'b0, 0);
				r1 = fill_word(target);
			end
			cpu_pkg::op_st:
				expect_transfer(target, 1'b1, row.b);
			cpu_pkg::op_addi, cpu_pkg::op_andi, cpu_pkg::op_ori, cpu_pkg::op_ldi:
				r1 = alu_rule(row.op, row.a, sign_extend(row.imm));
			cpu_pkg::op_neg, cpu_pkg::op_not:
				r1 = alu_rule(row.op, row.a, row.a);
			default:
				r1 = alu_rule(row.op, row.a, row.b);
		endcase
		expect_transfer(reset_pc + 3, 1'b0, 0);
		expect_transfer(row.addr, 1'b1, r1);
		expect_transfer(reset_pc + 4, 1'b0, 0);
	endtask

	task automatic apply_reset;
		reset = 1'b1;
		pready = 1'b0;
		repeat (2) begin
			@(posedge clk);
			#1;
		end
		check_flag("psel", psel, 1'b0);
		check_flag("penable", penable, 1'b0);
		check_flag("pwrite", pwrite, 1'b0);
		check_flag("halted", halted, 1'b0);
		reset = 1'b0;
	endtask

	// APB slave with random wait states, compared against the expected transfers
	task automatic run_program(input int row_index);
		int cycles;
		int delay;
		int waits;
		logic active;
		logic completing;
		logic [word_width-1:0] t_addr;
		logic [word_width-1:0] t_data;
		logic [word_width-1:0] want_data;
		logic t_write;
		cycles = 0;
		delay = 0;
		waits = 0;
		active = 1'b0;
		completing = 1'b0;
		while (!halted) begin
			@(posedge clk);
			#1;
			cycles++;
			if (cycles > run_limit)
				report_failure($sformatf("Timeout: row %0d never reached halt", row_index));
			if (completing) begin
				if (t_write)
					mem[t_addr[7:0]] = t_data;
				completing = 1'b0;
				active = 1'b0;
				pready = 1'b0;
			end
			if (psel && !penable) begin
				if (active)
					report_failure("APB setup started before the previous transfer ended");
				if (expect_addr.size() == 0)
					report_failure("APB transfer started after the last expected one");
				if (paddr >= mem_depth)
					report_failure("APB address is outside the memory model");
				t_addr = paddr;
				t_write = pwrite;
				t_data = pwdata;
				want_data = expect_data.pop_front();
				check_word("paddr", paddr, expect_addr.pop_front());
				check_flag("pwrite", pwrite, expect_write.pop_front());
				if (t_write)
					check_word("pwdata", pwdata, want_data);
				delay = $urandom_range(3, 0);
				waits = 0;
				active = 1'b1;
			end else if (psel && penable) begin
				if (!active)
					report_failure("APB access phase came without a setup phase");
				check_word("paddr", paddr, t_addr);
				check_flag("pwrite", pwrite, t_write);
				check_word("pwdata", pwdata, t_data);
				if (waits == delay) begin
					prdata = mem[t_addr[7:0]];
					pready = 1'b1;
					completing = 1'b1;
				end else begin
					waits++;
				end
			end else begin
				check_flag("penable", penable, 1'b0);
				if (active)
					report_failure("psel dropped before pready");
			end
		end
		if (expect_addr.size() != 0)
			report_failure($sformatf("Row %0d halted with transfers still missing", row_index));
		repeat (5) begin
			@(posedge clk);
			#1;
			check_flag("halted", halted, 1'b1);
			check_flag("psel", psel, 1'b0);
		end
	endtask

	initial begin
		row_t row;
		clk = 1'b0;
		reset = 1'b1;
		pready = 1'b0;
		prdata = '0;
		void'($urandom(32'hea0f));
		build_table();
		foreach (table_rows[i]) begin
			row = table_rows[i];
			if (row.rand_a)
				row.a = $urandom();
			if (row.rand_b)
				row.b = $urandom();
			load_program(row);
			apply_reset();
			run_program(i);
		end
		$display("Verification passed");
		$finish;
	end

endmodule

`default_nettype wire

//--- verilog/alu.sv
`timescale 1ns/1ns
`default_nettype none

module alu (
	input  cpu_pkg::opcode_e op,
	input  logic [cpu_pkg::word_width-1:0] a,
	input  logic [cpu_pkg::word_width-1:0] b,
	output logic [cpu_pkg::word_width-1:0] result
);

	logic [4:0] amount;

	// Shift and rotate distance comes from the low bits of b
	assign amount = b[4:0];

	always_comb begin
		case (op)
			// Address calculation shares the adder
			cpu_pkg::op_add,
			cpu_pkg::op_addi,
			cpu_pkg::op_ld,
			cpu_pkg::op_ldi,
			cpu_pkg::op_st:
				result = a + b;
			cpu_pkg::op_sub:
				result = a - b;
			cpu_pkg::op_shr:
				result = a >> amount;
			cpu_pkg::op_shra:
				result = $unsigned($signed(a) >>> amount);
			cpu_pkg::op_shl:
				result = a << amount;
			// Shift by word_width gives zero, so amount 0 returns a
			cpu_pkg::op_ror:
				result = (a >> amount) | (a << (cpu_pkg::word_width - amount));
			cpu_pkg::op_rol:
				result = (a << amount) | (a >> (cpu_pkg::word_width - amount));
			cpu_pkg::op_and,
			cpu_pkg::op_andi:
				result = a & b;
			cpu_pkg::op_or,
			cpu_pkg::op_ori:
				result = a | b;
			// Unary ops ignore Y
			cpu_pkg::op_neg:
				result = ~b + 1'b1;
			cpu_pkg::op_not:
				result = ~b;
			default:
				result = '0;
		endcase
	end

endmodule

`default_nettype wire

//--- verilog/control_unit.sv
`timescale 1ns/1ns
`default_nettype none

module control_unit (
	input  logic clk,
	input  logic reset,
	input  cpu_pkg::opcode_e ir_opcode,
	input  logic pready,
	output logic pc_out,
	output logic z_out,
	output logic mdr_out,
	output logic r_out,
	output logic c_out,
	output logic pc_enable,
	output logic pc_increment,
	output logic mar_enable,
	output logic mdr_enable,
	output logic mdr_read,
	output logic ir_enable,
	output logic y_enable,
	output logic z_enable,
	output logic r_enable,
	output logic gra,
	output logic grb,
	output logic grc,
	output cpu_pkg::opcode_e alu_op,
	output logic psel,
	output logic penable,
	output logic pwrite,
	output logic halted
);

	cpu_pkg::step_e state;
	cpu_pkg::step_e next_state;
	logic is_load;
	logic is_store;
	logic is_halt;
	logic is_reg_op;
	logic is_imm_op;
	logic is_unary;
	logic is_known;

	// Opcode classes
	always_comb begin
		is_reg_op = 1'b0;
		is_imm_op = 1'b0;
		is_unary = 1'b0;
		case (ir_opcode)
			cpu_pkg::op_add, cpu_pkg::op_sub, cpu_pkg::op_shr, cpu_pkg::op_shra,
			cpu_pkg::op_shl, cpu_pkg::op_ror, cpu_pkg::op_rol, cpu_pkg::op_and,
			cpu_pkg::op_or:
				is_reg_op = 1'b1;
			cpu_pkg::op_ld, cpu_pkg::op_ldi, cpu_pkg::op_st, cpu_pkg::op_addi,
			cpu_pkg::op_andi, cpu_pkg::op_ori:
				is_imm_op = 1'b1;
			cpu_pkg::op_neg, cpu_pkg::op_not:
				is_unary = 1'b1;
			default:
				is_reg_op = 1'b0;
		endcase
	end

	assign is_load = ir_opcode == cpu_pkg::op_ld;
	assign is_store = ir_opcode == cpu_pkg::op_st;
	assign is_halt = ir_opcode == cpu_pkg::op_halt;
	assign is_known = is_reg_op | is_imm_op | is_unary;

	always_ff @(posedge clk) begin
		if (reset)
			state <= cpu_pkg::fetch0;
		else
			state <= next_state;
	end

	always_comb begin
		next_state = state;
		case (state)
			cpu_pkg::fetch0:
				next_state = cpu_pkg::fetch1;
			cpu_pkg::fetch1:
				next_state = cpu_pkg::fetch_wait;
			cpu_pkg::fetch_wait:
				if (pready)
					next_state = cpu_pkg::fetch2;
			cpu_pkg::fetch2:
				next_state = cpu_pkg::exec3;
			// IR holds the new instruction from here on
			// Unknown opcodes fall straight back to fetch
			cpu_pkg::exec3:
				if (is_halt)
					next_state = cpu_pkg::halted_s;
				else if (is_known)
					next_state = cpu_pkg::exec4;
				else
					next_state = cpu_pkg::fetch0;
			cpu_pkg::exec4:
				next_state = cpu_pkg::exec5;
			cpu_pkg::exec5:
				if (is_load)
					next_state = cpu_pkg::mem_setup;
				else if (is_store)
					next_state = cpu_pkg::exec7;
				else
					next_state = cpu_pkg::fetch0;
			// exec7 comes before the transfer for st and after it for ld
			cpu_pkg::exec7:
				next_state = is_store ? cpu_pkg::mem_setup : cpu_pkg::fetch0;
			cpu_pkg::mem_setup:
				next_state = cpu_pkg::mem_wait;
			cpu_pkg::mem_wait:
				if (pready)
					next_state = is_load ? cpu_pkg::exec7 : cpu_pkg::fetch0;
			cpu_pkg::halted_s:
				next_state = cpu_pkg::halted_s;
			default:
				next_state = cpu_pkg::fetch0;
		endcase
	end

	always_comb begin
		pc_out = 1'b0;
		z_out = 1'b0;
		mdr_out = 1'b0;
		r_out = 1'b0;
		c_out = 1'b0;
		pc_enable = 1'b0;
		pc_increment = 1'b0;
		mar_enable = 1'b0;
		mdr_enable = 1'b0;
		mdr_read = 1'b0;
		ir_enable = 1'b0;
		y_enable = 1'b0;
		z_enable = 1'b0;
		r_enable = 1'b0;
		gra = 1'b0;
		grb = 1'b0;
		grc = 1'b0;
		alu_op = cpu_pkg::op_add;
		psel = 1'b0;
		penable = 1'b0;
		pwrite = 1'b0;
		case (state)
			// MAR <- PC, Z <- PC+1
			cpu_pkg::fetch0: begin
				pc_out = 1'b1;
				mar_enable = 1'b1;
				pc_increment = 1'b1;
				z_enable = 1'b1;
			end
			// PC <- Z, APB setup for the read
			cpu_pkg::fetch1: begin
				z_out = 1'b1;
				pc_enable = 1'b1;
				psel = 1'b1;
			end
			cpu_pkg::fetch_wait: begin
				psel = 1'b1;
				penable = 1'b1;
				mdr_read = 1'b1;
				mdr_enable = pready;
			end
			cpu_pkg::fetch2: begin
				mdr_out = 1'b1;
				ir_enable = 1'b1;
			end
			cpu_pkg::exec3: begin
				r_out = 1'b1;
				grb = 1'b1;
				y_enable = 1'b1;
			end
			// Second operand is rc, rb or the constant
			cpu_pkg::exec4: begin
				z_enable = 1'b1;
				alu_op = ir_opcode;
				if (is_imm_op) begin
					c_out = 1'b1;
				end else begin
					r_out = 1'b1;
					grc = is_reg_op;
					grb = is_unary;
				end
			end
			cpu_pkg::exec5: begin
				z_out = 1'b1;
				if (is_load || is_store) begin
					mar_enable = 1'b1;
				end else begin
					r_enable = 1'b1;
					gra = 1'b1;
				end
			end
			cpu_pkg::exec7: begin
				gra = 1'b1;
				if (is_store) begin
					r_out = 1'b1;
					mdr_enable = 1'b1;
				end else begin
					mdr_out = 1'b1;
					r_enable = 1'b1;
				end
			end
			cpu_pkg::mem_setup: begin
				psel = 1'b1;
				pwrite = is_store;
			end
			cpu_pkg::mem_wait: begin
				psel = 1'b1;
				penable = 1'b1;
				pwrite = is_store;
				mdr_read = is_load;
				mdr_enable = is_load & pready;
			end
			default: begin
				alu_op = cpu_pkg::op_add;
			end
		endcase
	end

	assign halted = state == cpu_pkg::halted_s;

endmodule

`default_nettype wire

//--- verilog/cpu_pkg.sv
`default_nettype none

package cpu_pkg;

	// Bus and register file sizing
	localparam int word_width = 32;
	localparam int reg_count = 16;
	localparam int reg_addr_width = $clog2(reg_count);

	// Instruction opcodes, bits 31:27 of the instruction word
	typedef enum logic [4:0] {
		op_ld   = 5'd0,
		op_ldi  = 5'd1,
		op_st   = 5'd2,
		op_add  = 5'd3,
		op_sub  = 5'd4,
		op_shr  = 5'd5,
		op_shra = 5'd6,
		op_shl  = 5'd7,
		op_ror  = 5'd8,
		op_rol  = 5'd9,
		op_and  = 5'd10,
		op_or   = 5'd11,
		op_addi = 5'd12,
		op_andi = 5'd13,
		op_ori  = 5'd14,
		op_neg  = 5'd17,
		op_not  = 5'd18,
		op_halt = 5'd27
	} opcode_e;

	// Control steps, one clock each except the two wait steps
	typedef enum logic [3:0] {
		fetch0, fetch1, fetch_wait, fetch2,
		exec3, exec4, exec5,
		mem_setup, mem_wait, exec7,
		halted_s
	} step_e;

endpackage

`default_nettype wire

//--- verilog/cpu_top.sv
`timescale 1ns/1ns
`default_nettype none

module cpu_top #(
	parameter logic [cpu_pkg::word_width-1:0] reset_pc = '0
) (
	input  logic clk,
	input  logic reset,
	input  logic pready,
	input  logic [cpu_pkg::word_width-1:0] prdata,
	output logic psel,
	output logic penable,
	output logic pwrite,
	output logic [cpu_pkg::word_width-1:0] paddr,
	output logic [cpu_pkg::word_width-1:0] pwdata,
	output logic halted
);

	// Bus-out selects
	logic pc_out;
	logic z_out;
	logic mdr_out;
	logic r_out;
	logic c_out;

	// Register loads
	logic pc_enable;
	logic pc_increment;
	logic mar_enable;
	logic mdr_enable;
	logic mdr_read;
	logic ir_enable;
	logic y_enable;
	logic z_enable;
	logic r_enable;

	// Register field selects
	logic gra;
	logic grb;
	logic grc;

	cpu_pkg::opcode_e alu_op;
	cpu_pkg::opcode_e ir_opcode;

	control_unit u_control_unit (.*);

	datapath #(
		.reset_pc(reset_pc)
	) u_datapath (.*);

endmodule

`default_nettype wire

//--- verilog/datapath.sv
`timescale 1ns/1ns
`default_nettype none

module datapath #(
	parameter logic [cpu_pkg::word_width-1:0] reset_pc = '0
) (
	input  logic clk,
	input  logic reset,
	input  logic pc_out,
	input  logic z_out,
	input  logic mdr_out,
	input  logic r_out,
	input  logic c_out,
	input  logic pc_enable,
	input  logic pc_increment,
	input  logic mar_enable,
	input  logic mdr_enable,
	input  logic mdr_read,
	input  logic ir_enable,
	input  logic y_enable,
	input  logic z_enable,
	input  logic r_enable,
	input  logic gra,
	input  logic grb,
	input  logic grc,
	input  cpu_pkg::opcode_e alu_op,
	input  logic [cpu_pkg::word_width-1:0] prdata,
	output logic [cpu_pkg::word_width-1:0] paddr,
	output logic [cpu_pkg::word_width-1:0] pwdata,
	output cpu_pkg::opcode_e ir_opcode
);

	logic [cpu_pkg::word_width-1:0] bus;
	logic [cpu_pkg::word_width-1:0] pc;
	logic [cpu_pkg::word_width-1:0] mar;
	logic [cpu_pkg::word_width-1:0] mdr;
	logic [cpu_pkg::word_width-1:0] ir;
	logic [cpu_pkg::word_width-1:0] y;
	logic [cpu_pkg::word_width-1:0] z;
	logic [cpu_pkg::word_width-1:0] rdata;
	logic [cpu_pkg::word_width-1:0] constant;
	logic [cpu_pkg::word_width-1:0] alu_result;
	logic [cpu_pkg::reg_addr_width-1:0] reg_sel;

	// Instruction fields
	assign ir_opcode = cpu_pkg::opcode_e'(ir[31:27]);
	assign constant = {{(cpu_pkg::word_width - 19){ir[18]}}, ir[18:0]};

	// Select-and-encode of ra, rb, rc
	assign reg_sel = ({cpu_pkg::reg_addr_width{gra}} & ir[26:23])
		| ({cpu_pkg::reg_addr_width{grb}} & ir[22:19])
		| ({cpu_pkg::reg_addr_width{grc}} & ir[18:15]);

	// Bus source, at most one select high
	always_comb begin
		if (pc_out)
			bus = pc;
		else if (z_out)
			bus = z;
		else if (mdr_out)
			bus = mdr;
		else if (r_out)
			bus = rdata;
		else if (c_out)
			bus = constant;
		else
			bus = '0;
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			pc <= reset_pc;
			ir <= '0;
		end else begin
			if (pc_enable)
				pc <= bus;
			if (ir_enable)
				ir <= bus;
		end
	end

	always_ff @(posedge clk) begin
		if (mar_enable)
			mar <= bus;
		if (mdr_enable)
			mdr <= mdr_read ? prdata : bus;
		if (y_enable)
			y <= bus;
		// PC+1 skips the ALU during fetch
		if (z_enable)
			z <= pc_increment ? bus + 1'b1 : alu_result;
	end

	assign paddr = mar;
	assign pwdata = mdr;

	register_file u_register_file (
		.clk(clk),
		.reset(reset),
		.sel(reg_sel),
		.write_enable(r_enable),
		.bus(bus),
		.rdata(rdata)
	);

	alu u_alu (
		.op(alu_op),
		.a(y),
		.b(bus),
		.result(alu_result)
	);

endmodule

`default_nettype wire

//--- verilog/register_file.sv
`timescale 1ns/1ns
`default_nettype none

module register_file (
	input  logic clk,
	input  logic reset,
	input  logic [cpu_pkg::reg_addr_width-1:0] sel,
	input  logic write_enable,
	input  logic [cpu_pkg::word_width-1:0] bus,
	output logic [cpu_pkg::word_width-1:0] rdata
);

	logic [cpu_pkg::word_width-1:0] regs [cpu_pkg::reg_count];

	// Single port: the same register is read and written
	always_ff @(posedge clk) begin
		if (reset) begin
			for (int i = 0; i < cpu_pkg::reg_count; i++) begin
				regs[i] <= '0;
			end
		end else if (write_enable) begin
			regs[sel] <= bus;
		end
	end

	assign rdata = regs[sel];

endmodule

`default_nettype wire
